//--- list.f
+incdir+src
src/cgra_tile_pkg.sv
src/tile_crossbar.sv
src/operand_stage.sv
src/tile_alu.sv
src/load_store_unit.sv
src/writeback_stage.sv
src/cgra_tile.sv
tb/cgra_tile_chk.sv
tb/tb_cgra_tile.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_cgra_tile -f list.f \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_cgra_tile)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1

//--- src/cgra_tile.sv
// --------------------
// one processing element, three steps from config to result
// i_mem_rdata must be valid before the step after the request
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "cgra_tile_consts.svh"

module cgra_tile (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    i_start_exec,
    input  cgra_tile_pkg::config_t                  i_config,
    input  cgra_tile_pkg::flit_t [`NUM_DIRS-1:0]    i_flit_in,
    input  logic [`DATA_W-1:0]                      i_mem_rdata,
    output cgra_tile_pkg::flit_t [`NUM_DIRS-1:0]    o_flit_out,
    output cgra_tile_pkg::mem_req_t                 o_mem
);
    import cgra_tile_pkg::*;

    flit_t              rhs;
    flit_t              lhs;
    flit_t              pred;
    flit_t              result;
    flit_t              treg;
    flit_t              wb;
    operands_t          ops;
    logic [`DATA_W-1:0] alu_value;
    logic               wb_treg_we;

    tile_crossbar u_crossbar (
        .clk        (clk),
        .reset      (reset),
        .i_step     (i_start_exec),
        .i_flit_in  (i_flit_in),
        .i_result   (result),
        .i_treg     (treg),
        .i_cfg      (i_config),
        .o_flit_out (o_flit_out),
        .o_rhs      (rhs),
        .o_lhs      (lhs),
        .o_pred     (pred)
    );

    operand_stage u_operands (
        .clk    (clk),
        .reset  (reset),
        .i_step (i_start_exec),
        .i_rhs  (rhs),
        .i_lhs  (lhs),
        .i_pred (pred),
        .i_cfg  (i_config),
        .o_ops  (ops)
    );

    tile_alu u_alu (
        .i_ops   (ops),
        .o_value (alu_value)
    );

    load_store_unit u_lsu (
        .clk         (clk),
        .reset       (reset),
        .i_step      (i_start_exec),
        .i_ops       (ops),
        .i_alu_value (alu_value),
        .i_mem_rdata (i_mem_rdata),
        .o_mem       (o_mem),
        .o_wb        (wb),
        .o_treg_we   (wb_treg_we)
    );

    writeback_stage u_writeback (
        .clk       (clk),
        .reset     (reset),
        .i_step    (i_start_exec),
        .i_wb      (wb),
        .i_treg_we (wb_treg_we),
        .o_result  (result),
        .o_treg    (treg)
    );

endmodule

`default_nettype wire

//--- src/cgra_tile_consts.svh
// --------------------
// widths and field sizes of the tile configuration format
// these are fixed by the 64-bit config word, not tunable per instance
// --------------------
`ifndef CGRA_TILE_CONSTS_SVH
`define CGRA_TILE_CONSTS_SVH

// datapath
`define DATA_W      32

// source select code per crossbar output
`define SEL_W       3

// opcode field
`define OPC_W       5

// sign-extended immediate in the config word
`define CONST_W     27

// reserved bits at the top of the config word
`define RSVD_W      8

// word address and byte lane of the memory port
`define ADDR_W      9
`define LANE_W      2

// neighbour links
`define NUM_DIRS    4

`endif

//--- src/cgra_tile_pkg.sv
// --------------------
// shared flit, config, operand and memory request types of the tile
// config fields are declared msb first, so sel_out sits at bit 0
// --------------------
`default_nettype none

`include "cgra_tile_consts.svh"

package cgra_tile_pkg;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] data;
    } flit_t;

    // code 6 is unused and routes a zero flit like SRC_NONE
    typedef enum logic [`SEL_W-1:0] {
        SRC_N      = 3'd0,
        SRC_E      = 3'd1,
        SRC_S      = 3'd2,
        SRC_W      = 3'd3,
        SRC_RESULT = 3'd4,
        SRC_TREG   = 3'd5,
        SRC_NONE   = 3'd7
    } src_sel_e;

    typedef enum logic [`OPC_W-1:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
        OP_CMPEQ, OP_SELECT, OP_LOAD_W, OP_LOAD_H, OP_LOAD_B,
        OP_STORE_W, OP_STORE_H, OP_STORE_B
    } opcode_e;

    typedef struct packed {
        logic [`RSVD_W-1:0]         reserved;
        logic                       pred_inv;
        logic [`CONST_W-1:0]        const_val;
        logic                       const_en;
        opcode_e                    opcode;
        logic                       treg_we;
        src_sel_e                   sel_pred;
        src_sel_e                   sel_lhs;
        src_sel_e                   sel_rhs;
        src_sel_e [`NUM_DIRS-1:0]   sel_out;
    } config_t;

    typedef struct packed {
        flit_t                  rhs;
        flit_t                  lhs;
        flit_t                  pred;
        opcode_e                opcode;
        logic                   const_en;
        logic [`CONST_W-1:0]    const_val;
        logic                   treg_we;
        logic                   skip;
    } operands_t;

    // strobes and lane enables are active low
    typedef struct packed {
        logic               rd_n;
        logic               wr_n;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic [`DATA_W-1:0] bit_en;
    } mem_req_t;

    function automatic logic [`DATA_W-1:0] const_ext(input logic [`CONST_W-1:0] c);
        return {{(`DATA_W-`CONST_W){c[`CONST_W-1]}}, c};
    endfunction

endpackage

`default_nettype wire

//--- src/load_store_unit.sv
// --------------------
// memory request issued at step k+1 and load lane extracted before step k+2
// word accesses ignore the lane bits; a half access at lane 1 or 3 issues
// nothing and its load returns zero
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "cgra_tile_consts.svh"

module load_store_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_step,
    input  cgra_tile_pkg::operands_t    i_ops,
    input  logic [`DATA_W-1:0]          i_alu_value,
    input  logic [`DATA_W-1:0]          i_mem_rdata,
    output cgra_tile_pkg::mem_req_t     o_mem,
    output cgra_tile_pkg::flit_t        o_wb,
    output logic                        o_treg_we
);
    import cgra_tile_pkg::*;

    localparam mem_req_t REQ_IDLE = '{rd_n: 1'b1, wr_n: 1'b1, addr: '0, wdata: '0, bit_en: '1};

    logic [`DATA_W-1:0] addr_src;
    logic [`LANE_W-1:0] lane;
    logic               is_load;
    logic               is_store;
    logic               aligned;
    logic               issue;
    logic [3:0]         lane_mask;
    logic [`DATA_W-1:0] wdata;
    mem_req_t           req_next;

    // state carried from step k+1 to writeback
    opcode_e            op_q;
    logic [`LANE_W-1:0] lane_q;
    logic [`DATA_W-1:0] alu_q;
    logic               skip_q;
    logic [`DATA_W-1:0] rdata_sh;

    // --------------------
    // request build
    // --------------------
    assign addr_src = i_ops.const_en ? const_ext(i_ops.const_val) : i_ops.lhs.data;
    assign lane     = addr_src[`LANE_W-1:0];

    assign is_load  = i_ops.opcode inside {OP_LOAD_W, OP_LOAD_H, OP_LOAD_B};
    assign is_store = i_ops.opcode inside {OP_STORE_W, OP_STORE_H, OP_STORE_B};

    always_comb
    begin
        aligned = 1'b1;
        case (i_ops.opcode)
            OP_LOAD_H, OP_STORE_H:
            begin
                lane_mask = 4'b0011 << lane;
                wdata     = {16'b0, i_ops.rhs.data[15:0]} << {lane, 3'b000};
                aligned   = !lane[0];
            end
            OP_LOAD_B, OP_STORE_B:
            begin
                lane_mask = 4'b0001 << lane;
                wdata     = {24'b0, i_ops.rhs.data[7:0]} << {lane, 3'b000};
            end
            default:
            begin
                lane_mask = 4'b1111;
                wdata     = i_ops.rhs.data;
            end
        endcase
    end

    always_comb
    begin
        req_next.rd_n  = 1'b0;
        req_next.wr_n  = !is_store;
        req_next.addr  = addr_src[`ADDR_W+`LANE_W-1:`LANE_W];
        req_next.wdata = is_store ? wdata : '0;
        for (int i = 0; i < 4; i++)
        begin
            req_next.bit_en[8*i +: 8] = {8{~lane_mask[i]}};
        end
    end

    assign issue = (is_load || is_store) && !i_ops.skip && aligned;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_mem     <= REQ_IDLE;
            op_q      <= OP_NOP;
            skip_q    <= 1'b0;
            o_treg_we <= 1'b0;
        end
        else if (i_step)
        begin
            o_mem     <= issue ? req_next : REQ_IDLE;
            op_q      <= i_ops.opcode;
            skip_q    <= i_ops.skip;
            o_treg_we <= i_ops.treg_we;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_step)
        begin
            alu_q  <= i_alu_value;
            lane_q <= lane;
        end
    end

    // --------------------
    // load lane extraction
    // --------------------
    assign rdata_sh = i_mem_rdata >> {lane_q, 3'b000};

    always_comb
    begin
        o_wb.valid = !skip_q;
        case (op_q)
            OP_LOAD_W:  o_wb.data = i_mem_rdata;
            OP_LOAD_H:  o_wb.data = lane_q[0] ? '0 : {16'b0, rdata_sh[15:0]};
            OP_LOAD_B:  o_wb.data = {24'b0, rdata_sh[7:0]};
            default:    o_wb.data = alu_q;
        endcase
    end

endmodule

`default_nettype wire

//--- src/operand_stage.sv
// --------------------
// captures operands and instruction fields at step k
// an operand counts as selected for any code other than SRC_NONE
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "cgra_tile_consts.svh"

module operand_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_step,
    input  cgra_tile_pkg::flit_t        i_rhs,
    input  cgra_tile_pkg::flit_t        i_lhs,
    input  cgra_tile_pkg::flit_t        i_pred,
    input  cgra_tile_pkg::config_t      i_cfg,
    output cgra_tile_pkg::operands_t    o_ops
);
    import cgra_tile_pkg::*;

    flit_t  pred_eff;
    logic   rhs_used;
    logic   lhs_used;
    logic   pred_used;
    logic   pred_fail;
    logic   skip_all;
    logic   skip_sel;
    logic   skip;

    // pred_inv flips only bit 0 of the predicate data
    assign pred_eff.valid = i_pred.valid;
    assign pred_eff.data  = {i_pred.data[`DATA_W-1:1], i_pred.data[0] ^ i_cfg.pred_inv};

    assign rhs_used  = (i_cfg.sel_rhs != SRC_NONE);
    assign lhs_used  = (i_cfg.sel_lhs != SRC_NONE);
    assign pred_used = (i_cfg.sel_pred != SRC_NONE);

    assign pred_fail = pred_used && (!pred_eff.valid || (pred_eff.data == '0));

    // --------------------
    // skip rules
    // --------------------
    // the constant stands in for a missing lhs
    assign skip_all = (rhs_used && !i_rhs.valid)
                    || (lhs_used && !i_lhs.valid && !i_cfg.const_en)
                    || pred_fail;

    // select only needs one of its two inputs
    assign skip_sel = (!i_rhs.valid && !i_lhs.valid) || pred_fail;

    assign skip = (i_cfg.opcode == OP_SELECT) ? skip_sel : skip_all;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_ops <= '0;
        end
        else if (i_step)
        begin
            o_ops.rhs       <= i_rhs;
            o_ops.lhs       <= i_lhs;
            o_ops.pred      <= pred_eff;
            o_ops.opcode    <= i_cfg.opcode;
            o_ops.const_en  <= i_cfg.const_en;
            o_ops.const_val <= i_cfg.const_val;
            o_ops.treg_we   <= i_cfg.treg_we;
            o_ops.skip      <= skip;
        end
    end

endmodule

`default_nettype wire

//--- src/tile_alu.sv
// --------------------
// combinational ALU on the captured operands
// left operand is rhs, right operand is lhs or the extended constant
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "cgra_tile_consts.svh"

module tile_alu (
    input  cgra_tile_pkg::operands_t    i_ops,
    output logic [`DATA_W-1:0]          o_value
);
    import cgra_tile_pkg::*;

    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;

    assign a = i_ops.rhs.data;
    assign b = i_ops.const_en ? const_ext(i_ops.const_val) : i_ops.lhs.data;

    always_comb
    begin
        case (i_ops.opcode)
            OP_ADD:     o_value = a + b;
            OP_SUB:     o_value = a - b;
            OP_AND:     o_value = a & b;
            OP_OR:      o_value = a | b;
            OP_XOR:     o_value = a ^ b;
            OP_SHL:     o_value = a << b[4:0];
            OP_SHR:     o_value = a >> b[4:0];
            OP_CMPEQ:   o_value = {{(`DATA_W-1){1'b0}}, (a == b)};
            // falls back to the right operand when rhs is missing
            OP_SELECT:  o_value = i_ops.rhs.valid ? a : b;
            // memory ops and nop
            default:    o_value = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/tile_crossbar.sv
// --------------------
// six-source crossbar whose neighbour outputs are registered on each step
// operand slots are combinational and sampled by the operand stage
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "cgra_tile_consts.svh"

module tile_crossbar (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    i_step,
    input  cgra_tile_pkg::flit_t [`NUM_DIRS-1:0]    i_flit_in,
    input  cgra_tile_pkg::flit_t                    i_result,
    input  cgra_tile_pkg::flit_t                    i_treg,
    input  cgra_tile_pkg::config_t                  i_cfg,
    output cgra_tile_pkg::flit_t [`NUM_DIRS-1:0]    o_flit_out,
    output cgra_tile_pkg::flit_t                    o_rhs,
    output cgra_tile_pkg::flit_t                    o_lhs,
    output cgra_tile_pkg::flit_t                    o_pred
);
    import cgra_tile_pkg::*;

    // index order matches the source codes 0..5
    flit_t [5:0] src;

    function automatic flit_t sel_flit(input src_sel_e sel, input flit_t [5:0] srcs);
        flit_t f;
        f = '0;
        if (sel <= SRC_TREG)
        begin
            f = srcs[sel];
        end
        return f;
    endfunction

    assign src = {i_treg, i_result, i_flit_in};

    assign o_rhs  = sel_flit(i_cfg.sel_rhs, src);
    assign o_lhs  = sel_flit(i_cfg.sel_lhs, src);
    assign o_pred = sel_flit(i_cfg.sel_pred, src);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_flit_out <= '0;
        end
        else if (i_step)
        begin
            for (int d = 0; d < `NUM_DIRS; d++)
            begin
                o_flit_out[d] <= sel_flit(i_cfg.sel_out[d], src);
            end
        end
    end

endmodule

`default_nettype wire

//--- src/writeback_stage.sv
// --------------------
// result and treg registers, loaded at step k+2
// --------------------
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i_step,
    input  cgra_tile_pkg::flit_t    i_wb,
    input  logic                    i_treg_we,
    output cgra_tile_pkg::flit_t    o_result,
    output cgra_tile_pkg::flit_t    o_treg
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_result <= '0;
            o_treg   <= '0;
        end
        else if (i_step)
        begin
            o_result <= i_wb;
            // treg holds its value unless the op asked for a write
            if (i_treg_we)
            begin
                o_treg <= i_wb;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/cgra_tile_chk.sv
// --------------------
// concurrent checks on the memory port of cgra_tile
// failures count up in assert_fails for the testbench summary
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "cgra_tile_consts.svh"

module cgra_tile_chk (
    input  logic                        clk,
    input  logic                        reset,
    input  cgra_tile_pkg::mem_req_t     i_mem
);

    int   assert_fails = 0;
    logic req_idle;

    assign req_idle = i_mem.rd_n && i_mem.wr_n && (i_mem.addr == '0)
                    && (i_mem.wdata == '0) && (i_mem.bit_en == '1);

    // a store always comes with the read strobe
    a_wr_has_rd: assert property (@(posedge clk) disable iff (reset)
        !i_mem.wr_n |-> !i_mem.rd_n)
    else
    begin
        assert_fails++;
        $error("write strobe low while read strobe high");
    end

    a_active_has_lanes: assert property (@(posedge clk) disable iff (reset)
        !i_mem.rd_n |-> (i_mem.bit_en != '1))
    else
    begin
        assert_fails++;
        $error("active request with no byte lane enabled");
    end

    a_idle_in_reset: assert property (@(posedge clk) reset |=> req_idle)
    else
    begin
        assert_fails++;
        $error("memory request not idle during reset");
    end

endmodule

`default_nettype wire

//--- tb/tb_cgra_tile.sv
// --------------------
// directed testbench for cgra_tile with one step per clock while running
// memory model answers reads combinationally and writes on the clock
// word accesses are only issued at lane 0
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "cgra_tile_consts.svh"

module tb_cgra_tile;
    import cgra_tile_pkg::*;

    localparam int CLK_NS      = 100;
    localparam int DRIVE_NS    = 5;
    // upper bound on the steps of all tests together
    localparam int TOTAL_STEPS = 190;
    localparam mem_req_t REQ_IDLE = '{rd_n: 1'b1, wr_n: 1'b1, addr: '0, wdata: '0, bit_en: '1};

    logic                   clk;
    logic                   reset;
    logic                   start_exec;
    config_t                cfg;
    flit_t [`NUM_DIRS-1:0]  flit_in;
    flit_t [`NUM_DIRS-1:0]  flit_out;
    mem_req_t               mem_req;
    logic [`DATA_W-1:0]     mem_rdata;
    logic [`DATA_W-1:0]     mem [0:(1<<`ADDR_W)-1];
    logic [31:0]            lfsr;
    int                     checks;
    int                     errors;
    int                     test_start;
    int                     tests;
    int                     tests_failed;

    cgra_tile dut_i (
        .clk          (clk),
        .reset        (reset),
        .i_start_exec (start_exec),
        .i_config     (cfg),
        .i_flit_in    (flit_in),
        .i_mem_rdata  (mem_rdata),
        .o_flit_out   (flit_out),
        .o_mem        (mem_req)
    );

    bind cgra_tile cgra_tile_chk chk_i (.clk(clk), .reset(reset), .i_mem(o_mem));

    always #(CLK_NS/2) clk = ~clk;

    // --------------------
    // memory model
    // --------------------
    assign mem_rdata = mem[mem_req.addr];

    always @(posedge clk)
    begin
        if (!mem_req.wr_n)
        begin
            mem[mem_req.addr] <= (mem[mem_req.addr] & mem_req.bit_en)
                               | (mem_req.wdata & ~mem_req.bit_en);
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 and one shift per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic flit_t rand_flit(input logic valid);
        flit_t f;
        f.valid = valid;
        f.data  = rand_bits(`DATA_W);
        return f;
    endfunction

    function automatic config_t idle_cfg();
        config_t c;
        c          = '0;
        c.opcode   = OP_NOP;
        c.sel_rhs  = SRC_NONE;
        c.sel_lhs  = SRC_NONE;
        c.sel_pred = SRC_NONE;
        for (int d = 0; d < `NUM_DIRS; d++)
        begin
            c.sel_out[d] = SRC_NONE;
        end
        return c;
    endfunction

    function automatic config_t op_cfg(input opcode_e op, input src_sel_e rs,
                                       input src_sel_e ls, input src_sel_e ps);
        config_t c;
        c          = idle_cfg();
        c.opcode   = op;
        c.sel_rhs  = rs;
        c.sel_lhs  = ls;
        c.sel_pred = ps;
        return c;
    endfunction

    function automatic config_t route_cfg(input int d, input src_sel_e src);
        config_t c;
        c            = idle_cfg();
        c.sel_out[d] = src;
        return c;
    endfunction

    // expected ALU value where the right operand is lhs or the sign-extended constant
    function automatic logic [`DATA_W-1:0] alu_expect(input opcode_e op, input flit_t rhs,
            input flit_t lhs, input logic ce, input logic [`CONST_W-1:0] cv);
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] v;
        if (ce)
        begin
            b = {{(`DATA_W-`CONST_W){cv[`CONST_W-1]}}, cv};
        end
        else
        begin
            b = lhs.data;
        end
        case (op)
            OP_ADD:     v = rhs.data + b;
            OP_SUB:     v = rhs.data - b;
            OP_AND:     v = rhs.data & b;
            OP_OR:      v = rhs.data | b;
            OP_XOR:     v = rhs.data ^ b;
            OP_SHL:     v = rhs.data << b[4:0];
            OP_SHR:     v = rhs.data >> b[4:0];
            OP_CMPEQ:   v = (rhs.data == b) ? 32'd1 : 32'd0;
            OP_SELECT:  v = rhs.valid ? rhs.data : b;
            default:    v = '0;
        endcase
        return v;
    endfunction

    // --------------------
    // drive and compare
    // --------------------
    task automatic step(input config_t c);
        cfg        = c;
        start_exec = 1'b1;
        @(posedge clk);
        #DRIVE_NS;
    endtask

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mem(input string name, input mem_req_t got, input mem_req_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic begin_test();
        test_start = errors;
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - test_start;
        tests++;
        if (n == 0)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, n);
        end
    endtask

    // op at step k with its result registered at k+2 and routed out at k+3
    task automatic run_to_result(input config_t c, input flit_t exp);
        step(c);
        step(idle_cfg());
        step(idle_cfg());
        step(route_cfg(0, SRC_RESULT));
        check_flit("o_flit_out[0]", flit_out[0], exp);
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_routing();
        config_t     c;
        flit_t       exp;
        logic [31:0] r;
        logic [2:0]  sel [`NUM_DIRS];
        begin_test();
        for (int n = 0; n < 8; n++)
        begin
            c = idle_cfg();
            for (int d = 0; d < `NUM_DIRS; d++)
            begin
                r           = rand_bits(1);
                flit_in[d]  = rand_flit(r[0]);
                r           = rand_bits(3);
                // codes 4 and 5 need pipeline state, so they map to SRC_NONE here
                sel[d]      = (r[2:0] == 3'd4 || r[2:0] == 3'd5) ? 3'd7 : r[2:0];
                c.sel_out[d] = src_sel_e'(sel[d]);
            end
            step(c);
            for (int d = 0; d < `NUM_DIRS; d++)
            begin
                if (sel[d] < 3'd4)
                begin
                    exp = flit_in[sel[d][1:0]];
                end
                else
                begin
                    exp = '0;
                end
                check_flit($sformatf("o_flit_out[%0d]", d), flit_out[d], exp);
            end
        end
        end_test("routing");
    endtask

    task automatic test_alu();
        config_t     c;
        flit_t       rhs;
        flit_t       lhs;
        flit_t       exp;
        logic [31:0] r;
        begin_test();
        for (int i = int'(OP_ADD); i <= int'(OP_SELECT); i++)
        begin
            for (int ce = 0; ce < 2; ce++)
            begin
                rhs = rand_flit(1'b1);
                lhs = rand_flit(1'b1);
                // one equal pair so compare sees both outcomes
                if (opcode_e'(i) == OP_CMPEQ && ce == 0)
                begin
                    lhs.data = rhs.data;
                end
                r           = rand_bits(`CONST_W);
                c           = op_cfg(opcode_e'(i), SRC_N, SRC_E, SRC_NONE);
                c.const_en  = (ce == 1);
                c.const_val = r[`CONST_W-1:0];
                flit_in[0]  = rhs;
                flit_in[1]  = lhs;
                exp.valid   = 1'b1;
                exp.data    = alu_expect(c.opcode, rhs, lhs, c.const_en, c.const_val);
                run_to_result(c, exp);
            end
        end
        end_test("alu");
    endtask

    task automatic skip_case(input config_t c, input logic rv, input logic lv,
                             input logic pv, input logic [31:0] pd, input logic exp_valid);
        flit_t rhs;
        flit_t lhs;
        flit_t exp;
        rhs        = rand_flit(rv);
        lhs        = rand_flit(lv);
        flit_in[0] = rhs;
        flit_in[1] = lhs;
        flit_in[2] = '{valid: pv, data: pd};
        exp.valid  = exp_valid;
        exp.data   = alu_expect(c.opcode, rhs, lhs, c.const_en, c.const_val);
        run_to_result(c, exp);
    endtask

    task automatic test_skip();
        config_t c;
        begin_test();
        c = op_cfg(OP_ADD, SRC_N, SRC_E, SRC_NONE);
        skip_case(c, 1'b0, 1'b1, 1'b1, 32'd1, 1'b0);
        skip_case(c, 1'b1, 1'b0, 1'b1, 32'd1, 1'b0);
        // constant covers the missing lhs
        c.const_en  = 1'b1;
        c.const_val = 27'h00_1234;
        skip_case(c, 1'b1, 1'b0, 1'b1, 32'd1, 1'b1);
        c = op_cfg(OP_ADD, SRC_N, SRC_E, SRC_S);
        skip_case(c, 1'b1, 1'b1, 1'b1, 32'd0, 1'b0);
        skip_case(c, 1'b1, 1'b1, 1'b0, 32'd5, 1'b0);
        c.pred_inv = 1'b1;
        skip_case(c, 1'b1, 1'b1, 1'b1, 32'd1, 1'b0);
        skip_case(c, 1'b1, 1'b1, 1'b1, 32'd0, 1'b1);
        c = op_cfg(OP_SELECT, SRC_N, SRC_E, SRC_NONE);
        skip_case(c, 1'b0, 1'b0, 1'b1, 32'd1, 1'b0);
        skip_case(c, 1'b0, 1'b1, 1'b1, 32'd1, 1'b1);
        skip_case(c, 1'b1, 1'b0, 1'b1, 32'd1, 1'b1);
        // skipped store leaves the port idle
        c          = op_cfg(OP_STORE_W, SRC_N, SRC_E, SRC_S);
        flit_in[0] = rand_flit(1'b1);
        flit_in[1] = '{valid: 1'b1, data: 32'h0000_0040};
        flit_in[2] = '{valid: 1'b1, data: 32'd0};
        step(c);
        step(idle_cfg());
        check_mem("o_mem", mem_req, REQ_IDLE);
        end_test("skip");
    endtask

    // one store or load, address from the constant or from lhs
    task automatic mem_case(input opcode_e op, input logic [1:0] lane, input logic use_const);
        config_t            c;
        mem_req_t           exp_req;
        flit_t              exp_wb;
        logic [31:0]        a32;
        logic [31:0]        keep;
        logic [31:0]        rdata;
        logic [3:0]         bytes;
        logic               is_store;
        logic               half;
        is_store   = op inside {OP_STORE_W, OP_STORE_H, OP_STORE_B};
        half       = (op == OP_STORE_H) || (op == OP_LOAD_H);
        a32        = rand_bits(32);
        a32[1:0]   = lane;
        flit_in[0] = rand_flit(1'b1);
        flit_in[1] = '{valid: 1'b1, data: a32};
        c = op_cfg(op, is_store ? SRC_N : SRC_NONE, use_const ? SRC_NONE : SRC_E, SRC_NONE);
        c.const_en  = use_const;
        c.const_val = {16'b0, a32[10:0]};
        if (op == OP_STORE_W || op == OP_LOAD_W)
        begin
            bytes = 4'b1111;
        end
        else if (half)
        begin
            bytes = 4'b0011 << lane;
        end
        else
        begin
            bytes = 4'b0001 << lane;
        end
        for (int b = 0; b < 4; b++)
        begin
            keep[8*b +: 8] = {8{bytes[b]}};
        end
        // the store of the previous case is written at this edge
        step(c);
        rdata          = mem[a32[10:2]];
        exp_req.rd_n   = 1'b0;
        exp_req.wr_n   = !is_store;
        exp_req.addr   = a32[10:2];
        exp_req.wdata  = is_store ? ((flit_in[0].data << (8 * lane)) & keep) : 32'd0;
        exp_req.bit_en = ~keep;
        exp_wb.valid   = 1'b1;
        exp_wb.data    = (rdata & keep) >> (8 * lane);
        if (half && lane[0])
        begin
            exp_req     = REQ_IDLE;
            exp_wb.data = '0;
        end
        step(idle_cfg());
        check_mem("o_mem", mem_req, exp_req);
        if (!is_store)
        begin
            step(idle_cfg());
            step(route_cfg(0, SRC_RESULT));
            check_flit("o_flit_out[0]", flit_out[0], exp_wb);
        end
    endtask

    task automatic test_stores();
        begin_test();
        mem_case(OP_STORE_W, 2'd0, 1'b1);
        for (int l = 0; l < 4; l++)
        begin
            mem_case(OP_STORE_H, l[1:0], l[0]);
            mem_case(OP_STORE_B, l[1:0], !l[0]);
        end
        end_test("stores");
    endtask

    task automatic test_loads();
        begin_test();
        mem_case(OP_LOAD_W, 2'd0, 1'b0);
        mem_case(OP_LOAD_H, 2'd0, 1'b1);
        mem_case(OP_LOAD_H, 2'd2, 1'b0);
        mem_case(OP_LOAD_H, 2'd1, 1'b1);
        for (int l = 0; l < 4; l++)
        begin
            mem_case(OP_LOAD_B, l[1:0], l[1]);
        end
        end_test("loads");
    endtask

    task automatic test_treg();
        config_t c;
        flit_t   exp;
        begin_test();
        flit_in[0] = rand_flit(1'b1);
        flit_in[1] = rand_flit(1'b1);
        exp.valid  = 1'b1;
        exp.data   = flit_in[0].data + flit_in[1].data;
        c          = op_cfg(OP_ADD, SRC_N, SRC_E, SRC_NONE);
        c.treg_we  = 1'b1;
        step(c);
        // second op without treg_we must leave treg alone
        flit_in[0] = rand_flit(1'b1);
        c.treg_we  = 1'b0;
        step(c);
        step(idle_cfg());
        step(idle_cfg());
        step(route_cfg(1, SRC_TREG));
        check_flit("o_flit_out[1]", flit_out[1], exp);
        c           = op_cfg(OP_ADD, SRC_TREG, SRC_NONE, SRC_NONE);
        c.const_en  = 1'b1;
        c.const_val = 27'd1;
        exp.data    = exp.data + 32'd1;
        run_to_result(c, exp);
        end_test("treg");
    endtask

    // --------------------
    // main sequence and watchdog
    // --------------------
    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        start_exec   = 1'b0;
        cfg          = idle_cfg();
        flit_in      = '0;
        lfsr         = 32'hc64c40f5;
        checks       = 0;
        errors       = 0;
        test_start   = 0;
        tests        = 0;
        tests_failed = 0;
        for (int a = 0; a < (1 << `ADDR_W); a++)
        begin
            mem[a] = rand_bits(32) ^ {23'b0, a[8:0]};
        end
        repeat (8) @(posedge clk);
        #DRIVE_NS;
        reset = 1'b0;
        test_routing();
        test_alu();
        test_skip();
        test_stores();
        test_loads();
        test_treg();
        errors = errors + dut_i.chk_i.assert_fails;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests, tests_failed, checks, errors, dut_i.chk_i.assert_fails);
        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial
    begin
        #((8 + TOTAL_STEPS * 3) * CLK_NS + 20 * CLK_NS);
        $display("watchdog expired: the tests did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
